//--- logic/obuf_write_pkg.sv
package obuf_write_pkg;

    // Output buffer geometry
    localparam int bank_num    = 3;
    localparam int bank_addr_w = 9;

    // Job setting widths
    localparam int tile_w     = 6;
    localparam int setting_w  = 4;
    localparam int bits_w     = 2;
    localparam int bits_cnt_w = 4;

    typedef logic [bank_addr_w-1:0] bank_addr_t;

    // Code 2'b01 was fully connected and is not handled here
    typedef enum logic [1:0] {
        mode_conv   = 2'b00,
        mode_deconv = 2'b10,
        mode_dwc    = 2'b11
    } conv_mode_e;

    typedef enum logic [1:0] {
        st_init = 2'd0,
        st_idle = 2'd1,
        st_calc = 2'd2
    } write_state_e;

    // Held stable by the issuer while a job runs
    typedef struct packed {
        conv_mode_e            mode;
        logic                  bk_combine;
        logic [setting_w-1:0]  ker_size;
        logic [setting_w-1:0]  ker_strd;
        logic [bits_w-1:0]     bit_serial;
        logic [tile_w-1:0]     tile_size_x;
        logic [tile_w-1:0]     tile_size_y;
    } job_cfg_t;

    typedef struct packed {
        logic tick;
        logic warmup_done;
        logic strd_gap;
    } window_status_t;

    typedef struct packed {
        logic row_end;
        logic tile_end;
    } tile_status_t;

endpackage

//--- logic/obuf_write_fsm.sv
`timescale 1ns/1ps

module obuf_write_fsm (
    input  logic                           clk,
    input  logic                           rst,
    input  obuf_write_pkg::job_cfg_t       cfg,
    input  logic                           start,
    input  obuf_write_pkg::window_status_t win,
    input  obuf_write_pkg::tile_status_t   tile,
    output obuf_write_pkg::write_state_e   state,
    output logic                           write_fire,
    output logic                           done
);

    obuf_write_pkg::write_state_e state_next;
    logic                         mode_valid;
    logic                         single_tap;

    // Only the convolution style modes produce writes
    assign mode_valid = (cfg.mode == obuf_write_pkg::mode_conv)
                     || (cfg.mode == obuf_write_pkg::mode_deconv)
                     || (cfg.mode == obuf_write_pkg::mode_dwc);

    assign single_tap = (cfg.ker_size == obuf_write_pkg::setting_w'(1));

    always_comb begin
        state_next = state;
        case (state)
            obuf_write_pkg::st_init: begin
                if (start) begin
                    if (single_tap) begin
                        state_next = obuf_write_pkg::st_calc;
                    end else begin
                        state_next = obuf_write_pkg::st_idle;
                    end
                end
            end
            obuf_write_pkg::st_idle: begin
                if (win.warmup_done) begin
                    state_next = obuf_write_pkg::st_calc;
                end
            end
            obuf_write_pkg::st_calc: begin
                if (tile.tile_end) begin
                    state_next = obuf_write_pkg::st_init;
                end else if (tile.row_end) begin
                    // A 1x1 kernel needs no warm-up before the next row
                    if (single_tap) begin
                        state_next = obuf_write_pkg::st_calc;
                    end else begin
                        state_next = obuf_write_pkg::st_idle;
                    end
                end else if (win.strd_gap) begin
                    state_next = obuf_write_pkg::st_idle;
                end
            end
            default: begin
                state_next = obuf_write_pkg::st_init;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= obuf_write_pkg::st_init;
        end else begin
            state <= state_next;
        end
    end

    assign write_fire = mode_valid && win.tick && (state == obuf_write_pkg::st_calc);

    // Registered so it lines up with the last write strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            done <= 1'b0;
        end else begin
            done <= mode_valid && (state == obuf_write_pkg::st_calc)
                 && (state_next == obuf_write_pkg::st_init);
        end
    end

endmodule

//--- logic/kernel_window_counter.sv
`timescale 1ns/1ps

module kernel_window_counter (
    input  logic                           clk,
    input  logic                           rst,
    input  obuf_write_pkg::job_cfg_t       cfg,
    input  obuf_write_pkg::write_state_e   state,
    input  logic                           row_end,
    output obuf_write_pkg::window_status_t win
);

    logic [obuf_write_pkg::bits_cnt_w-1:0] bits_cnt;
    logic [obuf_write_pkg::bits_cnt_w-1:0] bits_last;
    logic [obuf_write_pkg::setting_w-1:0]  size_cnt;
    logic [obuf_write_pkg::setting_w-1:0]  size_last;
    logic [obuf_write_pkg::setting_w-1:0]  strd_cnt;
    logic [obuf_write_pkg::setting_w-1:0]  strd_last;
    logic                                  strd_phase;
    logic                                  running;
    logic                                  single_tap;
    logic                                  tick;

    assign running    = (state != obuf_write_pkg::st_init);
    assign single_tap = (cfg.ker_size == obuf_write_pkg::setting_w'(1));

    assign bits_last = {{(obuf_write_pkg::bits_cnt_w - obuf_write_pkg::bits_w){1'b0}},
                        cfg.bit_serial};
    assign size_last = cfg.ker_size - obuf_write_pkg::setting_w'(2);
    assign strd_last = cfg.ker_strd - obuf_write_pkg::setting_w'(1);

    // One tick per bit-serial period, counter parked at zero when idle
    assign tick = running && (bits_cnt == bits_last);

    always_ff @(posedge clk) begin
        if (rst) begin
            bits_cnt <= '0;
        end else if (running && !tick) begin
            bits_cnt <= bits_cnt + 1'b1;
        end else begin
            bits_cnt <= '0;
        end
    end

    // Size phase covers the warm-up, stride phase the write spacing
    // A 1x1 kernel has no warm-up, so its rows live in stride phase
    always_ff @(posedge clk) begin
        if (rst) begin
            strd_phase <= 1'b0;
        end else if (!running || row_end) begin
            strd_phase <= single_tap;
        end else if (win.warmup_done) begin
            strd_phase <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            size_cnt <= '0;
        end else if (running && !strd_phase) begin
            if (tick) begin
                if (size_cnt == size_last) begin
                    size_cnt <= '0;
                end else begin
                    size_cnt <= size_cnt + 1'b1;
                end
            end
        end else begin
            size_cnt <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            strd_cnt <= '0;
        end else if (!running || !strd_phase || row_end) begin
            strd_cnt <= '0;
        end else if (tick) begin
            if (strd_cnt == strd_last) begin
                strd_cnt <= '0;
            end else begin
                strd_cnt <= strd_cnt + 1'b1;
            end
        end
    end

    assign win.tick        = tick;
    assign win.warmup_done = tick && (strd_phase ? (strd_cnt == strd_last)
                                                 : (size_cnt == size_last));
    assign win.strd_gap    = tick && strd_phase && (strd_cnt != strd_last);

endmodule

//--- logic/tile_position_counter.sv
`timescale 1ns/1ps

module tile_position_counter (
    input  logic                           clk,
    input  logic                           rst,
    input  obuf_write_pkg::job_cfg_t       cfg,
    input  obuf_write_pkg::write_state_e   state,
    input  obuf_write_pkg::window_status_t win,
    output obuf_write_pkg::tile_status_t   tile
);

    logic [obuf_write_pkg::tile_w-1:0] x_pos;
    logic [obuf_write_pkg::tile_w-1:0] y_pos;
    logic [obuf_write_pkg::tile_w-1:0] x_last;
    logic [obuf_write_pkg::tile_w-1:0] y_last;
    logic                              calc_tick;
    logic                              row_end;
    logic                              tile_end;

    assign x_last = cfg.tile_size_x - obuf_write_pkg::tile_w'(1);
    assign y_last = cfg.tile_size_y - obuf_write_pkg::tile_w'(1);

    // Ticks in st_calc always land with the stride counter at zero
    assign calc_tick = win.tick && (state == obuf_write_pkg::st_calc);
    assign row_end   = calc_tick && (x_pos == x_last);
    assign tile_end  = row_end && (y_pos == y_last);

    always_ff @(posedge clk) begin
        if (rst) begin
            x_pos <= '0;
            y_pos <= '0;
        end else if (calc_tick) begin
            if (row_end) begin
                x_pos <= '0;
                if (tile_end) begin
                    y_pos <= '0;
                end else begin
                    y_pos <= y_pos + 1'b1;
                end
            end else begin
                x_pos <= x_pos + 1'b1;
            end
        end
    end

    assign tile.row_end  = row_end;
    assign tile.tile_end = tile_end;

endmodule

//--- logic/bank_address_gen.sv
`timescale 1ns/1ps

module bank_address_gen (
    input  logic                                                    clk,
    input  logic                                                    rst,
    input  obuf_write_pkg::job_cfg_t                                cfg,
    input  obuf_write_pkg::write_state_e                            state,
    input  logic                                                    write_fire,
    input  logic                                                    row_end,
    input  logic                                                    deconv_phase,
    output logic [obuf_write_pkg::bank_num-1:0]                     write_en,
    output obuf_write_pkg::bank_addr_t [obuf_write_pkg::bank_num-1:0] write_addr
);

    logic [obuf_write_pkg::bank_num-1:0]                  bank_sel;
    logic [obuf_write_pkg::bank_num-1:0]                  bank_sel_init;
    obuf_write_pkg::bank_addr_t [obuf_write_pkg::bank_num-1:0] bank_addr;
    logic                                                 is_deconv;

    assign is_deconv = (cfg.mode == obuf_write_pkg::mode_deconv);

    // Combined banks use a single bank, or a pair for deconvolution
    always_comb begin
        if (!cfg.bk_combine) begin
            bank_sel_init = '1;
        end else if (is_deconv) begin
            bank_sel_init = {{(obuf_write_pkg::bank_num-2){1'b0}}, 2'b11};
        end else begin
            bank_sel_init = {{(obuf_write_pkg::bank_num-1){1'b0}}, 1'b1};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bank_sel <= '0;
        end else if (state == obuf_write_pkg::st_init) begin
            bank_sel <= bank_sel_init;
        end else if (write_fire && row_end) begin
            // Deconvolution walks the banks the other way
            if (is_deconv) begin
                bank_sel <= {bank_sel[0], bank_sel[obuf_write_pkg::bank_num-1:1]};
            end else begin
                bank_sel <= {bank_sel[obuf_write_pkg::bank_num-2:0],
                             bank_sel[obuf_write_pkg::bank_num-1]};
            end
        end
    end

    // Address counters run on across jobs
    for (genvar b = 0; b < obuf_write_pkg::bank_num; b++) begin : g_bank
        always_ff @(posedge clk) begin
            if (rst) begin
                bank_addr[b] <= '0;
            end else if (write_fire && bank_sel[b]) begin
                bank_addr[b] <= bank_addr[b] + 1'b1;
            end
        end

        always_ff @(posedge clk) begin
            if (rst) begin
                write_addr[b] <= '0;
            end else if (is_deconv) begin
                write_addr[b] <= {bank_addr[b][obuf_write_pkg::bank_addr_w-1:1], deconv_phase};
            end else begin
                write_addr[b] <= bank_addr[b];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            write_en <= '0;
        end else begin
            write_en <= bank_sel & {obuf_write_pkg::bank_num{write_fire}};
        end
    end

endmodule

//--- logic/obuf_write_top.sv
`timescale 1ns/1ps

module obuf_write_top (
    input  logic                                                    clk,
    input  logic                                                    rst,
    input  obuf_write_pkg::job_cfg_t                                cfg,
    input  logic                                                    start,
    input  logic                                                    deconv_phase,
    output logic [obuf_write_pkg::bank_num-1:0]                     write_en,
    output obuf_write_pkg::bank_addr_t [obuf_write_pkg::bank_num-1:0] write_addr,
    output logic                                                    done
);

    obuf_write_pkg::write_state_e   state;
    obuf_write_pkg::window_status_t win;
    obuf_write_pkg::tile_status_t   tile;
    logic                           write_fire;

    obuf_write_fsm i_fsm (
        .clk        (clk),
        .rst        (rst),
        .cfg        (cfg),
        .start      (start),
        .win        (win),
        .tile       (tile),
        .state      (state),
        .write_fire (write_fire),
        .done       (done)
    );

    // Bit-serial timing and kernel window phases
    kernel_window_counter i_window (
        .clk     (clk),
        .rst     (rst),
        .cfg     (cfg),
        .state   (state),
        .row_end (tile.row_end),
        .win     (win)
    );

    tile_position_counter i_tile (
        .clk   (clk),
        .rst   (rst),
        .cfg   (cfg),
        .state (state),
        .win   (win),
        .tile  (tile)
    );

    // Bank rotation and the registered write port
    bank_address_gen i_bank (
        .clk          (clk),
        .rst          (rst),
        .cfg          (cfg),
        .state        (state),
        .write_fire   (write_fire),
        .row_end      (tile.row_end),
        .deconv_phase (deconv_phase),
        .write_en     (write_en),
        .write_addr   (write_addr)
    );

endmodule

//--- testbench/tb_obuf_write_model.svh
`ifndef TB_OBUF_WRITE_MODEL_SVH
`define TB_OBUF_WRITE_MODEL_SVH

// One expected write strobe as seen on the output port
typedef struct packed {
    logic [obuf_write_pkg::bank_num-1:0]                       en;
    obuf_write_pkg::bank_addr_t [obuf_write_pkg::bank_num-1:0] addr;
    // Cycles since the previous write, zero where not checked
    logic [15:0]                                               gap;
    logic                                                      last;
} write_beat_t;

// Appends the writes of one job and advances the per-bank addresses
function automatic void append_job_beats(
    input  obuf_write_pkg::job_cfg_t                                  cfg,
    input  logic                                                      phase,
    inout  obuf_write_pkg::bank_addr_t [obuf_write_pkg::bank_num-1:0] addr,
    inout  write_beat_t                                               beats[$]
);
    logic [obuf_write_pkg::bank_num-1:0] sel;
    write_beat_t                         beat;
    logic                                deconv;
    int                                  period;
    if (cfg.mode == 2'b01) begin
        return;
    end
    deconv = (cfg.mode == obuf_write_pkg::mode_deconv);
    period = int'(cfg.bit_serial) + 1;
    if (!cfg.bk_combine) begin
        sel = '1;
    end else if (deconv) begin
        sel = 3'b011;
    end else begin
        sel = 3'b001;
    end
    for (int y = 0; y < int'(cfg.tile_size_y); y++) begin
        for (int x = 0; x < int'(cfg.tile_size_x); x++) begin
            beat.en = sel;
            for (int b = 0; b < obuf_write_pkg::bank_num; b++) begin
                beat.addr[b] = addr[b];
                if (deconv) begin
                    beat.addr[b][0] = phase;
                end
                if (sel[b]) begin
                    addr[b] = addr[b] + 1'b1;
                end
            end
            // Stride spacing inside a row, warm-up plus first tick at a row start
            if (x > 0) begin
                beat.gap = 16'(int'(cfg.ker_strd) * period);
            end else if (y > 0) begin
                beat.gap = 16'(int'(cfg.ker_size) * period);
            end else begin
                beat.gap = '0;
            end
            beat.last = (x == int'(cfg.tile_size_x) - 1) && (y == int'(cfg.tile_size_y) - 1);
            beats.push_back(beat);
        end
        // Bank set moves on at every row end
        if (deconv) begin
            sel = (sel >> 1) | (sel << (obuf_write_pkg::bank_num - 1));
        end else begin
            sel = (sel << 1) | (sel >> (obuf_write_pkg::bank_num - 1));
        end
    end
endfunction

`endif

//--- testbench/tb_obuf_write.sv
`timescale 1ns/1ps

module tb_obuf_write;

    `include "tb_obuf_write_model.svh"

    localparam int job_count  = 25;
    localparam int directed_n = 5;

    logic                                                      clk = 1'b0;
    logic                                                      rst;
    obuf_write_pkg::job_cfg_t                                  cfg;
    logic                                                      start;
    logic                                                      deconv_phase;
    logic [obuf_write_pkg::bank_num-1:0]                       write_en;
    obuf_write_pkg::bank_addr_t [obuf_write_pkg::bank_num-1:0] write_addr;
    logic                                                      done;

    write_beat_t                                               expect_q[$];
    write_beat_t                                               beat;
    obuf_write_pkg::bank_addr_t [obuf_write_pkg::bank_num-1:0] model_addr;
    obuf_write_pkg::job_cfg_t                                  jobs[job_count];
    logic                                                      job_phase[job_count];
    logic [31:0]                                               lfsr_state = 32'hc4bd;
    int                                                        cycle = 0;
    int                                                        cycle_limit = 1000;
    int                                                        last_write_cycle = 0;
    int                                                        jobs_done = 0;
    logic                                                      job_active = 1'b0;

    always #2 clk = ~clk;

    obuf_write_top i_dut (
        .clk          (clk),
        .rst          (rst),
        .cfg          (cfg),
        .start        (start),
        .deconv_phase (deconv_phase),
        .write_en     (write_en),
        .write_addr   (write_addr),
        .done         (done)
    );

    task automatic stop_with_failure();
        $display("Test failed");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic abort_run(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        stop_with_failure();
    endtask

    task automatic compare_value(input logic [31:0] got, input logic [31:0] expected,
                                 input string what);
        if (got !== expected) begin
            $display("CHECK FAILED at %0t: %s is %0h, expected %0h", $time, what, got, expected);
            stop_with_failure();
        end
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end else begin
            return s >> 1;
        end
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    function automatic obuf_write_pkg::job_cfg_t make_cfg(
        input logic [1:0] mode,
        input logic       comb,
        input int         ker,
        input int         strd,
        input int         bits,
        input int         size_x,
        input int         size_y
    );
        obuf_write_pkg::job_cfg_t c;
        c.mode        = obuf_write_pkg::conv_mode_e'(mode);
        c.bk_combine  = comb;
        c.ker_size    = obuf_write_pkg::setting_w'(ker);
        c.ker_strd    = obuf_write_pkg::setting_w'(strd);
        c.bit_serial  = obuf_write_pkg::bits_w'(bits);
        c.tile_size_x = obuf_write_pkg::tile_w'(size_x);
        c.tile_size_y = obuf_write_pkg::tile_w'(size_y);
        return c;
    endfunction

    function automatic obuf_write_pkg::job_cfg_t random_cfg();
        logic [1:0] mode;
        logic       comb;
        int         ker;
        int         strd;
        int         bits;
        int         size_x;
        int         size_y;
        mode   = 2'(take_bits(2));
        comb   = 1'(take_bits(1));
        ker    = int'(take_bits(2)) + 1;
        strd   = int'(take_bits(1)) + 1;
        bits   = int'(take_bits(2));
        size_x = int'(take_bits(3)) % 5 + 1;
        size_y = int'(take_bits(3)) % 5 + 1;
        return make_cfg(mode, comb, ker, strd, bits, size_x, size_y);
    endfunction

    // Upper bound on the cycles one job keeps the controller busy
    function automatic int job_cycle_bound(input obuf_write_pkg::job_cfg_t c);
        return int'(c.tile_size_y)
             * (int'(c.ker_size) - 1 + int'(c.tile_size_x) * int'(c.ker_strd))
             * (int'(c.bit_serial) + 1) + 4;
    endfunction

    task automatic run_job(input obuf_write_pkg::job_cfg_t c, input logic phase);
        int   done_before;
        logic writes;
        writes      = (c.mode != 2'b01);
        done_before = jobs_done;
        cfg          = c;
        deconv_phase = phase;
        if (writes) begin
            append_job_beats(c, phase, model_addr, expect_q);
            job_active = 1'b1;
        end
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        if (writes) begin
            wait (jobs_done != done_before);
            @(negedge clk);
        end else begin
            // The dropped mode still walks the tile without writing
            repeat (job_cycle_bound(c)) @(negedge clk);
        end
    endtask

    // Output checker, sampled away from the active clock edge
    always @(negedge clk) begin
        if (!rst) begin
            if (write_en != '0) begin
                if (expect_q.size() == 0) begin
                    abort_run("a write strobe arrived while no write was expected");
                end else begin
                    beat = expect_q.pop_front();
                    compare_value(32'(write_en), 32'(beat.en), "write_en");
                    for (int b = 0; b < obuf_write_pkg::bank_num; b++) begin
                        compare_value(32'(write_addr[b]), 32'(beat.addr[b]),
                                      $sformatf("write_addr[%0d]", b));
                    end
                    if (beat.gap != '0) begin
                        compare_value(32'(cycle - last_write_cycle), 32'(beat.gap),
                                      "cycles between writes");
                    end
                    compare_value(32'(done), 32'(beat.last), "done with this write");
                    last_write_cycle = cycle;
                end
            end
            if (done) begin
                if (!job_active) begin
                    abort_run("done pulsed while no job was running");
                end else if (expect_q.size() != 0) begin
                    abort_run("done pulsed while expected writes were still pending");
                end else begin
                    job_active = 1'b0;
                    jobs_done++;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= cycle_limit) begin
            abort_run($sformatf("the run did not finish within %0d cycles", cycle_limit));
        end
    end

    initial begin
        int limit;
        rst          = 1'b1;
        start        = 1'b0;
        cfg          = '0;
        deconv_phase = 1'b0;
        model_addr   = '0;

        // Directed jobs cover each mode and both bank layouts
        jobs[0] = make_cfg(2'b00, 1'b0, 3, 2, 1, 3, 2);
        jobs[1] = make_cfg(2'b00, 1'b1, 1, 1, 0, 2, 4);
        jobs[2] = make_cfg(2'b10, 1'b1, 2, 1, 2, 3, 3);
        jobs[3] = make_cfg(2'b11, 1'b1, 4, 2, 3, 2, 2);
        jobs[4] = make_cfg(2'b01, 1'b0, 2, 1, 1, 2, 2);
        job_phase[0] = 1'b0;
        job_phase[1] = 1'b0;
        job_phase[2] = 1'b1;
        job_phase[3] = 1'b0;
        job_phase[4] = 1'b1;
        for (int j = directed_n; j < job_count; j++) begin
            jobs[j]      = random_cfg();
            job_phase[j] = 1'(take_bits(1));
        end

        limit = 40;
        for (int j = 0; j < job_count; j++) begin
            limit += job_cycle_bound(jobs[j]) + 2;
        end
        cycle_limit = limit;

        repeat (2) @(negedge clk);
        rst = 1'b0;

        // Quiet outputs before the first start
        repeat (8) begin
            @(negedge clk);
            compare_value(32'(write_en), 32'h0, "write_en before any start");
            compare_value(32'(done), 32'h0, "done before any start");
            for (int b = 0; b < obuf_write_pkg::bank_num; b++) begin
                compare_value(32'(write_addr[b]), 32'h0,
                              $sformatf("write_addr[%0d] after reset", b));
            end
        end

        for (int j = 0; j < job_count; j++) begin
            run_job(jobs[j], job_phase[j]);
        end
        repeat (4) @(negedge clk);

        if (expect_q.size() != 0) begin
            abort_run("expected writes never arrived");
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

//--- list.f
+incdir+testbench
logic/obuf_write_pkg.sv
logic/obuf_write_fsm.sv
logic/kernel_window_counter.sv
logic/tile_position_counter.sv
logic/bank_address_gen.sv
logic/obuf_write_top.sv
testbench/tb_obuf_write.sv

//--- Bender.yml
package:
  name: obuf_write

sources:
  - logic/obuf_write_pkg.sv
  - logic/obuf_write_fsm.sv
  - logic/kernel_window_counter.sv
  - logic/tile_position_counter.sv
  - logic/bank_address_gen.sv
  - logic/obuf_write_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_obuf_write.sv
